// ==== can_decoder.f ====
+incdir+sim
src/can_pkg.sv
src/can_bit_if.sv
src/can_bit_destuffer.sv
src/can_crc15.sv
src/can_frame_fsm.sv
src/can_field_capture.sv
src/can_decoder.sv
sim/tb_can_decoder.sv

// ==== Bender.yml ====
package:
  name: can_decoder

sources:
  - files:
      - src/can_pkg.sv
      - src/can_bit_if.sv
      - src/can_bit_destuffer.sv
      - src/can_crc15.sv
      - src/can_frame_fsm.sv
      - src/can_field_capture.sv
      - src/can_decoder.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_can_decoder.sv

// ==== sim/can_tb_model.svh ====
`ifndef CAN_TB_MODEL_SVH
`define CAN_TB_MODEL_SVH

// Expected outcome of one frame on the bus
typedef struct packed {
	logic        is_error;
	logic [2:0]  code;  // Error code when is_error is set
	logic [28:0] id;
	logic        ide;
	logic        rtr;
	logic [3:0]  dlc;
	logic [63:0] data;  // First byte on top
} result_t;

localparam logic [14:0] model_poly = 15'h4599;

// ====================
// Line stream of the frame being sent
// ====================
logic line_bits [0:299];  // Bus levels in send order
int   line_len;
int   first_stuff_index;  // Position of the first stuff bit
int   crc_delim_index;
int   ack_index;

// Shift a field onto the end of a raw bit accumulator
function automatic logic [127:0] append_field(input logic [127:0] acc, input logic [63:0] value,
	input int width);
	logic [127:0] mask;
	mask = (128'd1 << width) - 128'd1;
	return (acc << width) | ({64'd0, value} & mask);
endfunction

// CAN CRC-15 over the raw bits, oldest bit first
function automatic logic [14:0] crc15_of(input logic [127:0] raw, input int len);
	logic [14:0] crc;
	logic        feedback;
	int          k;
	crc = '0;
	for (k = 0; k < len; k++)
	begin
		feedback = raw[len-1-k] ^ crc[14];
		crc      = {crc[13:0], 1'b0};
		if (feedback)
			crc = crc ^ model_poly;
	end
	return crc;
endfunction

function automatic int clamp_dlc(input logic [3:0] dlc);
	return (dlc > 4'd8) ? 8 : int'(dlc);  // Codes 9 to 15 mean 8 bytes
endfunction

function automatic result_t expected_frame(input logic ide, input logic rtr,
	input logic [28:0] id, input logic [3:0] dlc, input logic [63:0] data);
	result_t r;
	int      n_bytes;
	r       = '0;
	r.id    = ide ? id : (id & 29'h7ff);  // Base ids right aligned
	r.ide   = ide;
	r.rtr   = rtr;
	r.dlc   = 4'(clamp_dlc(dlc));
	n_bytes = rtr ? 0 : clamp_dlc(dlc);  // Remote frames carry no data
	r.data  = (n_bytes == 0) ? 64'd0 : data & ~(64'hffff_ffff_ffff_ffff >> (8 * n_bytes));
	return r;
endfunction

// Raw fields, CRC, stuffing and the fixed tail into line_bits
task automatic build_frame(input logic ide, input logic rtr, input logic [28:0] id,
	input logic [3:0] dlc, input logic [63:0] data, input int flip_bit);
	logic [127:0] raw;
	logic [14:0]  crc;
	logic         run_value;
	logic         b;
	int           raw_len;
	int           data_start;
	int           n_bytes;
	int           run_len;
	int           k;
	raw     = append_field('0, 64'd0, 1);  // SOF
	raw_len = 1;
	if (ide)
	begin
		raw     = append_field(raw, id[28:18], 11);
		raw     = append_field(raw, 64'b11, 2);  // SRR and IDE recessive
		raw     = append_field(raw, id[17:0], 18);
		raw     = append_field(raw, {rtr, 2'b00}, 3);  // RTR r1 r0
		raw_len += 34;
	end
	else
	begin
		raw     = append_field(raw, id[10:0], 11);
		raw     = append_field(raw, {rtr, 2'b00}, 3);  // RTR IDE r0
		raw_len += 14;
	end
	raw        = append_field(raw, dlc, 4);
	raw_len    += 4;
	data_start = raw_len;
	n_bytes    = rtr ? 0 : clamp_dlc(dlc);
	for (k = 0; k < n_bytes; k++)
	begin
		raw     = append_field(raw, data[63-8*k -: 8], 8);
		raw_len += 8;
	end
	crc = crc15_of(raw, raw_len);
	if (flip_bit >= 0)
		raw[raw_len-1-data_start-flip_bit] = ~raw[raw_len-1-data_start-flip_bit];  // Bad after CRC
	raw     = append_field(raw, crc, 15);
	raw_len += 15;

	// Stuffing from SOF through the last CRC bit
	line_len          = 0;
	first_stuff_index = -1;
	run_len           = 0;
	run_value         = 1'b1;
	for (k = 0; k < raw_len; k++)
	begin
		b                   = raw[raw_len-1-k];
		line_bits[line_len] = b;
		line_len++;
		run_len   = (b == run_value) ? run_len + 1 : 1;
		run_value = b;
		if (run_len == 5)
		begin
			if (first_stuff_index < 0)
				first_stuff_index = line_len;
			line_bits[line_len] = ~b;  // Opposite level breaks the run
			line_len++;
			run_value = ~b;
			run_len   = 1;
		end
	end

	// CRC delimiter, ACK slot, ACK delimiter, EOF and intermission
	crc_delim_index = line_len;
	ack_index       = line_len + 1;
	for (k = 0; k < 13; k++)
		line_bits[line_len+k] = (k != 1);  // Only the ACK slot is dominant
	line_len += 13;
endtask

`endif

// ==== sim/tb_can_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_can_decoder;

	`include "can_tb_model.svh"

	localparam int          half_period = 20;
	localparam int          stim_delay  = 2;         // Drive after the rising edge
	localparam int          bit_cycles  = 4;         // Clocks per bus bit
	localparam int          wait_limit  = 400 * bit_cycles;
	localparam logic [31:0] rand_seed   = 32'h10720f4e;
	localparam logic [2:0]  code_stuff  = 3'd1;
	localparam logic [2:0]  code_crc    = 3'd2;
	localparam logic [2:0]  code_form   = 3'd3;
	localparam logic [2:0]  code_ack    = 3'd4;

	logic        clock;
	logic        reset;
	logic        rx_bit;
	logic        sample_point;
	logic        frame_valid;
	logic [28:0] frame_id;
	logic        frame_ide;
	logic        frame_rtr;
	logic [3:0]  frame_dlc;
	logic [63:0] frame_data;
	logic        error_valid;
	logic [2:0]  error_code;

	result_t expect_q [$];  // Results in bus order
	logic    all_sent;
	logic    checks_done;

	can_decoder uut (
		.clock(clock),
		.reset(reset),
		.rx_bit(rx_bit),
		.sample_point(sample_point),
		.frame_valid(frame_valid),
		.frame_id(frame_id),
		.frame_ide(frame_ide),
		.frame_rtr(frame_rtr),
		.frame_dlc(frame_dlc),
		.frame_data(frame_data),
		.error_valid(error_valid),
		.error_code(error_code)
	);

	always #half_period clock = ~clock;

	// ====================
	// Helpers
	// ====================
	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
			stop_run($sformatf("Mismatch %s got %h expected %h", name, got, exp));
	endtask

	// All decoded fields of a good frame
	task automatic check_fields(input result_t exp);
		check_value("frame_id", frame_id, exp.id);
		check_value("frame_ide", frame_ide, exp.ide);
		check_value("frame_rtr", frame_rtr, exp.rtr);
		check_value("frame_dlc", frame_dlc, exp.dlc);
		check_value("frame_data", frame_data, exp.data);
	endtask

	task automatic send_bit(input logic value);
		@(posedge clock);
		#stim_delay;
		rx_bit       = value;
		sample_point = 1'b1;  // One cycle strobe
		@(posedge clock);
		#stim_delay;
		sample_point = 1'b0;
		repeat (bit_cycles - 2) @(posedge clock);
	endtask

	task automatic send_idle(input int count);
		repeat (count) send_bit(1'b1);
	endtask

	task automatic send_line(input int count);
		int k;
		for (k = 0; k < count; k++)
			send_bit(line_bits[k]);
	endtask

	task automatic queue_frame(input logic ide, input logic rtr, input logic [28:0] id,
		input logic [3:0] dlc, input logic [63:0] data);
		expect_q.push_back(expected_frame(ide, rtr, id, dlc, data));
		build_frame(ide, rtr, id, dlc, data, -1);
	endtask

	task automatic queue_error(input logic [2:0] code);
		result_t r;
		r          = '0;
		r.is_error = 1'b1;
		r.code     = code;
		expect_q.push_back(r);
	endtask

	// Pulse seen, or nothing left to come
	task automatic wait_for_result(output logic got);
		int cycles;
		got = 1'b0;
		for (cycles = 0; cycles < wait_limit; cycles++)
		begin
			@(negedge clock);
			if (frame_valid || error_valid)
			begin
				got = 1'b1;
				return;
			end
			if (all_sent && expect_q.size() == 0)
				return;
		end
		stop_run("Timed out waiting for a frame or error result");
	endtask

	// ====================
	// Result checker
	// ====================
	initial
	begin : compare_results
		result_t exp;
		logic    got;
		int      cycles;
		checks_done = 1'b0;
		for (cycles = 0; cycles < 16 && reset !== 1'b0; cycles++)
			@(negedge clock);
		if (reset !== 1'b0)
			stop_run("Reset was never released");
		got = 1'b1;
		while (got)
		begin
			wait_for_result(got);
			if (got)
			begin
				if (expect_q.size() == 0)
					stop_run("Result pulse arrived with no frame pending");
				exp = expect_q.pop_front();
				check_value("error_valid", error_valid, exp.is_error);
				check_value("frame_valid", frame_valid, !exp.is_error);
				if (exp.is_error)
					check_value("error_code", error_code, exp.code);
				else
				begin
					check_fields(exp);
					@(negedge clock);  // Fields now come from the held copy
					check_value("frame_valid", frame_valid, 1'b0);
					check_fields(exp);
				end
			end
		end
		checks_done = 1'b1;
	end

	// ====================
	// Scenarios
	// ====================
	initial
	begin : run_scenarios
		logic [63:0] data;
		int          n;
		clock        = 1'b0;
		reset        = 1'b1;
		rx_bit       = 1'b1;  // Recessive idle bus
		sample_point = 1'b0;
		all_sent     = 1'b0;
		void'($urandom(rand_seed));
		repeat (2) @(posedge clock);
		#stim_delay;
		reset = 1'b0;
		send_idle(12);

		for (n = 0; n <= 8; n++)  // Base data frames, every length
		begin
			data = {$urandom, $urandom};
			queue_frame(1'b0, 1'b0, 29'($urandom) & 29'h7ff, 4'(n), data);
			send_line(line_len);
			send_idle(3);
		end

		queue_frame(1'b1, 1'b0, 29'($urandom), 4'($urandom % 9), {$urandom, $urandom});
		send_line(line_len);
		send_idle(3);
		queue_frame(1'b1, 1'b1, 29'($urandom), 4'($urandom % 9), {$urandom, $urandom});
		send_line(line_len);
		send_idle(3);

		// DLC codes above 8
		queue_frame(1'b0, 1'b0, 29'($urandom) & 29'h7ff, 4'(9 + $urandom % 7), {$urandom, $urandom});
		send_line(line_len);
		send_idle(3);
		queue_frame(1'b1, 1'b0, 29'($urandom), 4'd15, {$urandom, $urandom});
		send_line(line_len);
		send_idle(3);

		// Corrupted data bit then recovery
		queue_error(code_crc);
		build_frame(1'b0, 1'b0, 29'($urandom) & 29'h7ff, 4'd8, {$urandom, $urandom},
			int'($urandom % 64));
		send_line(line_len);
		send_idle(11);
		queue_frame(1'b0, 1'b0, 29'($urandom) & 29'h7ff, 4'd4, {$urandom, $urandom});
		send_line(line_len);
		send_idle(3);

		queue_error(code_stuff);
		build_frame(1'b0, 1'b0, 29'h07f, 4'd2, {$urandom, $urandom}, -1);  // SOF and 4 zeros
		line_bits[first_stuff_index] = ~line_bits[first_stuff_index];  // Sixth equal bit
		send_line(line_len);
		send_idle(11);

		queue_error(code_ack);
		build_frame(1'b0, 1'b0, 29'($urandom) & 29'h7ff, 4'd3, {$urandom, $urandom}, -1);
		line_bits[ack_index] = 1'b1;  // No receiver acknowledged
		send_line(line_len);
		send_idle(11);

		queue_error(code_form);
		build_frame(1'b1, 1'b0, 29'($urandom), 4'd1, {$urandom, $urandom}, -1);
		line_bits[crc_delim_index] = 1'b0;
		send_line(line_len);
		send_idle(11);

		// Second SOF on the last intermission bit
		queue_frame(1'b0, 1'b0, 29'($urandom) & 29'h7ff, 4'd2, {$urandom, $urandom});
		send_line(line_len - 1);
		queue_frame(1'b1, 1'b0, 29'($urandom), 4'd5, {$urandom, $urandom});
		send_line(line_len);
		send_idle(12);

		all_sent = 1'b1;
		for (n = 0; n < wait_limit && !checks_done; n++)
			@(negedge clock);
		if (checks_done)
		begin
			$display("All tests passed!");
			$finish;
		end
		else
			stop_run("Checker did not finish after the last frame");
	end

endmodule

`default_nettype wire

// ==== src/can_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module can_decoder
	import can_pkg::*;
(
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         rx_bit,
	input  logic                         sample_point,
	output logic                         frame_valid,
	output logic [len_id_a+len_id_b-1:0] frame_id,
	output logic                         frame_ide,
	output logic                         frame_rtr,
	output logic [len_dlc-1:0]           frame_dlc,
	output logic [8*max_data_bytes-1:0]  frame_data,
	output logic                         error_valid,
	output can_error_t                   error_code
);

	// ====================
	// Core units
	// ====================
	can_bit_if          bus_if ();
	frame_state_t       state;
	logic               crc_init;
	logic               crc_enable;
	logic [len_crc-1:0] crc_value;
	can_frame_t         frame;       // Live fields of the frame on the bus
	can_frame_t         frame_held;  // Copy of the last good frame
	can_frame_t         frame_out;

	can_bit_destuffer u_destuffer (.clock, .reset, .sample_point, .rx_bit, .bus(bus_if.source));

	can_crc15 u_crc (
		.clock,
		.reset,
		.crc_init,
		.crc_enable,
		.data_bit(bus_if.bit_value),
		.crc_value
	);

	can_frame_fsm u_fsm (
		.clock, .reset, .bus(bus_if.sink), .frame, .crc_value, .state,
		.crc_init, .crc_enable, .frame_valid, .error_valid, .error_code
	);

	can_field_capture u_capture (.clock, .reset, .bus(bus_if.monitor), .state, .frame);

	// ====================
	// Output hold
	// ====================
	always_ff @(posedge clock)
	begin
		if (frame_valid)
			frame_held <= frame;  // Next frame starts shifting right after this
	end

	assign frame_out = frame_valid ? frame : frame_held;  // Live copy during the pulse

	assign frame_id   = frame_out.id;
	assign frame_ide  = frame_out.ide;
	assign frame_rtr  = frame_out.rtr;
	assign frame_dlc  = frame_out.dlc;
	assign frame_data = frame_out.data << (8 * (max_data_bytes - frame_out.dlc));  // First byte on top

endmodule

`default_nettype wire

// ==== src/can_field_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

module can_field_capture
	import can_pkg::*;
(
	input  logic         clock,
	input  logic         reset,
	can_bit_if.monitor   bus,
	input  frame_state_t state,
	output can_frame_t   frame
);

	logic               bit_ok;     // Non stuffed bit on this strobe
	logic               sof;        // Dominant bit that opens a frame
	logic [len_dlc-1:0] dlc_shift;  // DLC register with the new bit shifted in
	logic [len_dlc-1:0] dlc_next;

	assign bit_ok = bus.bit_strobe && !bus.bit_stuffed;
	assign sof    = bit_ok && !bus.bit_value
		&& (state == st_idle || state == st_intermission);

	// Register starts at zero so partial shifts stay below 8
	assign dlc_shift = {frame.dlc[len_dlc-2:0], bus.bit_value};
	assign dlc_next  = (dlc_shift > len_dlc'(max_data_bytes)) ?
		len_dlc'(max_data_bytes) : dlc_shift;

	// ====================
	// Field shift registers
	// ====================
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			frame <= '0;
		end
		else if (sof)
		begin
			frame.id   <= '0;  // Base ids end up right aligned
			frame.dlc  <= '0;
			frame.data <= '0;  // Unused bytes read as zero
		end
		else if (bit_ok)
		begin
			case (state)
				st_id_a, st_id_b:
					frame.id <= {frame.id[$bits(frame.id)-2:0], bus.bit_value};
				st_rtr_srr, st_rtr:
					frame.rtr <= bus.bit_value;  // SRR gets overwritten by the real RTR
				st_ide:
					frame.ide <= bus.bit_value;
				st_dlc:
					frame.dlc <= dlc_next;
				st_data:
					frame.data <= {frame.data[$bits(frame.data)-2:0], bus.bit_value};
				st_crc:
					frame.crc <= {frame.crc[len_crc-2:0], bus.bit_value};
				default:
					;  // Fixed form bits carry no field
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/can_frame_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module can_frame_fsm
	import can_pkg::*;
(
	input  logic               clock,
	input  logic               reset,
	can_bit_if.sink            bus,
	input  can_frame_t         frame,       // Fields gathered so far
	input  logic [len_crc-1:0] crc_value,   // Locally computed CRC
	output frame_state_t       state,
	output logic               crc_init,
	output logic               crc_enable,
	output logic               frame_valid,
	output logic               error_valid,
	output can_error_t         error_code
);

	// ====================
	// Bit qualifiers
	// ====================
	logic               bit_ok;      // Real frame bit on this strobe
	logic [5:0]         bit_count;   // Shared position counter within a field
	logic [len_dlc-1:0] dlc_code;    // DLC including the bit being sampled
	logic [6:0]         data_bits;   // Data field length from the clamped DLC
	frame_state_t       next_state;
	can_error_t         error_next;
	logic               frame_good;

	assign bit_ok    = bus.bit_strobe && !bus.bit_stuffed;
	assign dlc_code  = {frame.dlc[len_dlc-2:0], bus.bit_value};
	assign data_bits = {frame.dlc, 3'b000};  // 8 bytes give 64 bits at most

	// CRC delimiter stays inside since a stuff bit may follow the last CRC bit
	assign bus.stuff_window = state inside {[st_id_a:st_crc_delimiter]};
	assign crc_enable       = bit_ok && (state inside {[st_id_a:st_data]});

	// ====================
	// Next state
	// ====================
	always_comb
	begin
		next_state = state;
		error_next = err_none;
		frame_good = 1'b0;
		crc_init   = 1'b0;
		if (bit_ok)
		begin
			case (state)
				st_idle:
					if (!bus.bit_value)  // Start of frame
					begin
						next_state = st_id_a;
						crc_init   = 1'b1;
					end
				st_id_a:
					if (bit_count == 6'(len_id_a - 1))
						next_state = st_rtr_srr;
				st_rtr_srr:
					next_state = st_ide;
				st_ide:
					next_state = bus.bit_value ? st_id_b : st_reserved0;  // Base frames skip to r0
				st_id_b:
					if (bit_count == 6'(len_id_b - 1))
						next_state = st_rtr;
				st_rtr:
					next_state = st_reserved1;
				st_reserved1:
					next_state = st_reserved0;
				st_reserved0:
					next_state = st_dlc;
				st_dlc:
					if (bit_count == 6'(len_dlc - 1))
						next_state = (frame.rtr || dlc_code == '0) ? st_crc : st_data;
				st_data:
					if ({1'b0, bit_count} == data_bits - 7'd1)
						next_state = st_crc;
				st_crc:
					if (bit_count == 6'(len_crc - 1))
						next_state = st_crc_delimiter;
				st_crc_delimiter:
					if (!bus.bit_value)
						error_next = err_form;
					else
						next_state = st_ack_slot;
				st_ack_slot:
					if (bus.bit_value)  // Nobody acknowledged
						error_next = err_ack;
					else
						next_state = st_ack_delimiter;
				st_ack_delimiter:
					if (crc_value != frame.crc)
						error_next = err_crc;
					else if (!bus.bit_value)
						error_next = err_form;
					else
					begin
						next_state = st_eof;
						frame_good = 1'b1;  // Reported before EOF is checked
					end
				st_eof:
					if (!bus.bit_value)
						error_next = err_form;
					else if (bit_count == 6'(len_eof - 1))
						next_state = st_intermission;
				st_intermission:
					if (bit_count == 6'(len_intermission - 1))
					begin
						next_state = bus.bit_value ? st_idle : st_id_a;  // Early SOF of next frame
						crc_init   = !bus.bit_value;
					end
					else if (!bus.bit_value)
						next_state = st_bus_wait;  // Overload condition so just resync
				st_bus_wait:
					if (bus.bit_value && bit_count == 6'(len_bus_idle - 1))
						next_state = st_idle;
				default:
					next_state = st_idle;
			endcase
		end
		if (bus.stuff_error)
			error_next = err_stuff;  // Wins over any field transition
		if (error_next != err_none)
			next_state = st_bus_wait;
	end

	// ====================
	// State and results
	// ====================
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state       <= st_idle;
			bit_count   <= '0;
			frame_valid <= 1'b0;
			error_valid <= 1'b0;
			error_code  <= err_none;
		end
		else
		begin
			state       <= next_state;
			frame_valid <= frame_good;
			error_valid <= (error_next != err_none);
			if (error_next != err_none)
				error_code <= error_next;  // Last code held between errors
			if (next_state != state)
				bit_count <= '0;
			else if (bit_ok)
				bit_count <= (state == st_bus_wait && !bus.bit_value) ? '0 : bit_count + 6'd1;
		end
	end

	results_exclusive: assert property (
		@(posedge clock) disable iff (reset)
		!(frame_valid && error_valid)
	);

endmodule

`default_nettype wire

// ==== src/can_crc15.sv ====
`timescale 1ns/1ns
`default_nettype none

module can_crc15
	import can_pkg::*;
(
	input  logic               clock,
	input  logic               reset,
	input  logic               crc_init,    // Start of frame seen
	input  logic               crc_enable,  // Non stuffed bit from SOF to data end
	input  logic               data_bit,
	output logic [len_crc-1:0] crc_value
);

	logic feedback;  // Incoming bit against the top register bit

	assign feedback = data_bit ^ crc_value[len_crc-1];

	// Serial CAN CRC with a zero start value
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			crc_value <= '0;
		end
		else if (crc_init)
		begin
			crc_value <= '0;  // SOF is dominant so it leaves the zero value alone
		end
		else if (crc_enable)
		begin
			crc_value <= {crc_value[len_crc-2:0], 1'b0} ^ (crc_poly & {len_crc{feedback}});
		end
	end

	// Init comes from idle or intermission and enable only inside the frame
	init_enable_apart: assert property (
		@(posedge clock) disable iff (reset)
		!(crc_init && crc_enable)
	);

endmodule

`default_nettype wire

// ==== src/can_bit_destuffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module can_bit_destuffer
	import can_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  logic      sample_point,  // One cycle strobe per bus bit
	input  logic      rx_bit,
	can_bit_if.source bus
);

	// ====================
	// Bit history
	// ====================
	logic [stuff_run-1:0] history;  // Newest bit in bit 0
	logic                 run_equal;  // Last five bits all the same

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			history <= stuff_run'('h15);  // Alternating so no run is seen at start
		end
		else if (sample_point)
		begin
			history <= {history[stuff_run-2:0], rx_bit};  // Stuff bits count toward the next run
		end
	end

	assign run_equal = (history == '0) || (history == '1);

	// ====================
	// Bit event
	// ====================
	assign bus.bit_strobe = sample_point;  // Same cycle as the sample
	assign bus.bit_value  = rx_bit;

	// Opposite bit after a run is the stuff bit
	assign bus.bit_stuffed = sample_point && bus.stuff_window && run_equal
		&& (rx_bit != history[0]);

	// A sixth equal bit breaks the stuffing rule
	assign bus.stuff_error = sample_point && bus.stuff_window && run_equal
		&& (rx_bit == history[0]);

endmodule

`default_nettype wire

// ==== src/can_bit_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// One sampled bus bit after stuff bit detection
interface can_bit_if;

	logic bit_strobe;    // High for one cycle per sample point
	logic bit_value;     // Sampled level and 1 is recessive
	logic bit_stuffed;   // This bit is a stuff bit
	logic stuff_error;   // Sixth equal bit inside the window
	logic stuff_window;  // Stuffing active for the current field

	modport source (
		output bit_strobe, bit_value, bit_stuffed, stuff_error,
		input  stuff_window
	);

	modport sink (
		input  bit_strobe, bit_value, bit_stuffed, stuff_error,
		output stuff_window
	);

	modport monitor (input bit_strobe, bit_value, bit_stuffed);  // Field capture only listens

endinterface

`default_nettype wire

// ==== src/can_pkg.sv ====
`default_nettype none

package can_pkg;

	// ====================
	// Field lengths in bits
	// ====================
	localparam int len_id_a         = 11;  // Base identifier
	localparam int len_id_b         = 18;  // Identifier extension
	localparam int len_dlc          = 4;
	localparam int len_crc          = 15;
	localparam int len_eof          = 7;
	localparam int len_intermission = 3;
	localparam int len_bus_idle     = 11;  // Recessive run to resync after an error

	localparam int stuff_run = 5;  // Equal bits before a stuff bit

	localparam logic [len_crc-1:0] crc_poly = 15'h4599;  // x^15+x^14+x^10+x^8+x^7+x^4+x^3+1

	localparam int max_data_bytes = 8;

	// ====================
	// Frame sequencer states
	// ====================
	// Order matters for the range checks in the FSM
	typedef enum logic [4:0] {
		st_idle,
		st_id_a,
		st_rtr_srr,        // RTR in base frames and SRR in extended ones
		st_ide,
		st_id_b,
		st_rtr,
		st_reserved1,
		st_reserved0,
		st_dlc,
		st_data,
		st_crc,
		st_crc_delimiter,  // Last state inside the stuff window
		st_ack_slot,
		st_ack_delimiter,
		st_eof,
		st_intermission,
		st_bus_wait        // Waiting for an idle bus after an error
	} frame_state_t;

	typedef enum logic [2:0] {
		err_none  = 3'd0,
		err_stuff = 3'd1,
		err_crc   = 3'd2,
		err_form  = 3'd3,
		err_ack   = 3'd4
	} can_error_t;

	// Fields of one received frame
	typedef struct packed {
		logic [len_id_a+len_id_b-1:0] id;    // Base id sits in the low 11 bits
		logic                         ide;
		logic                         rtr;
		logic [len_dlc-1:0]           dlc;   // Already clamped to 8
		logic [8*max_data_bytes-1:0]  data;  // Right aligned as received
		logic [len_crc-1:0]           crc;   // CRC field as sent
	} can_frame_t;

endpackage

`default_nettype wire
